//--- common/fpu_pkg.sv
package fpu_pkg;

    // Single-precision field widths
    localparam int EXP_W = 8;
    localparam int MAN_W = 23;

    // Width of the FCLASS one-hot mask
    localparam int CLASS_MASK_W = 10;

    typedef logic [31:0] fp32_t;  // Float value or integer result
    typedef logic [2:0]  frm_t;   // Function select for misc and compare ops

    // Same bit order as the fflags CSR
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    // Codes 0 to 12 belong to arithmetic and conversion ops
    typedef enum logic [3:0] {
        FPU_CLASS = 4'd13,
        FPU_CMP   = 4'd14,
        FPU_MISC  = 4'd15
    } fpu_op_e;

    typedef struct packed {
        logic sign;
        logic is_zero;
        logic is_subnormal;
        logic is_normal;
        logic is_inf;
        logic is_nan;
        logic is_snan;
    } fp_class_t;

    // Lane operation after decode
    typedef enum logic [3:0] {
        SGNJ,
        SGNJN,
        SGNJX,
        FMIN,
        FMAX,
        FEQ,
        FLT,
        FLE,
        FCLASS
    } noncomp_op_e;

    // Function field values under FPU_MISC
    localparam frm_t FRM_SGNJ  = 3'd0;
    localparam frm_t FRM_SGNJN = 3'd1;
    localparam frm_t FRM_SGNJX = 3'd2;
    localparam frm_t FRM_FMIN  = 3'd3;
    localparam frm_t FRM_FMAX  = 3'd4;

    // Function field values under FPU_CMP
    localparam frm_t FRM_FLE = 3'd0;
    localparam frm_t FRM_FLT = 3'd1;
    localparam frm_t FRM_FEQ = 3'd2;

    localparam fp32_t CANONICAL_NAN = 32'h7fc00000;

endpackage

//--- fpu/fpu_classify.sv
`timescale 1ns/1ns

module fpu_classify (
    input  fpu_pkg::fp32_t     value_i,
    output fpu_pkg::fp_class_t class_o
);
    import fpu_pkg::*;

    logic [EXP_W-1:0] exp_f;
    logic [MAN_W-1:0] man_f;
    logic             exp_zero;
    logic             exp_ones;
    logic             man_zero;

    // Fields and class bits are all taken from value_i in one pass
    always_comb begin
        exp_f    = value_i[MAN_W +: EXP_W];
        man_f    = value_i[MAN_W-1:0];
        exp_zero = (exp_f == '0);
        exp_ones = (exp_f == '1);
        man_zero = (man_f == '0);

        class_o.sign         = value_i[EXP_W+MAN_W];
        class_o.is_zero      = exp_zero & man_zero;
        class_o.is_subnormal = exp_zero & ~man_zero;
        class_o.is_normal    = ~exp_zero & ~exp_ones;
        class_o.is_inf       = exp_ones & man_zero;
        class_o.is_nan       = exp_ones & ~man_zero;
        class_o.is_snan      = exp_ones & ~man_zero & ~man_f[MAN_W-1];  // Quiet bit clear

        assert ($onehot({class_o.is_zero, class_o.is_subnormal, class_o.is_normal,
                         class_o.is_inf, class_o.is_nan}))
        else $error("fpu_classify: class bits of %h not one-hot", value_i);
    end

endmodule

//--- fpu/fpu_noncomp_lane.sv
`timescale 1ns/1ns

module fpu_noncomp_lane (
    input  fpu_pkg::noncomp_op_e op_i,
    input  fpu_pkg::fp32_t       a_i,
    input  fpu_pkg::fp32_t       b_i,
    output fpu_pkg::fp32_t       result_o,
    output fpu_pkg::fflags_t     fflags_o
);
    import fpu_pkg::*;

    fp_class_t               a_cls;
    fp_class_t               b_cls;
    logic                    any_nan;
    logic                    any_snan;
    logic                    both_zero;
    logic                    mag_lt;
    logic                    mag_gt;
    logic                    a_below_b;
    logic                    cmp_eq;
    logic                    cmp_lt;
    logic [CLASS_MASK_W-1:0] class_mask;

    fpu_classify classify_a_i (
        .value_i (a_i),
        .class_o (a_cls)
    );

    fpu_classify classify_b_i (
        .value_i (b_i),
        .class_o (b_cls)
    );

    assign any_nan   = a_cls.is_nan | b_cls.is_nan;
    assign any_snan  = a_cls.is_snan | b_cls.is_snan;
    assign both_zero = a_cls.is_zero & b_cls.is_zero;

    assign mag_lt = (a_i[30:0] < b_i[30:0]);
    assign mag_gt = (a_i[30:0] > b_i[30:0]);

    // Total order on non-NaN values, -0 sits below +0
    assign a_below_b = (a_i[31] != b_i[31]) ? a_i[31] :
                       (a_i[31] ? mag_gt : mag_lt);

    // Compares treat the two zeros as equal
    assign cmp_eq = ~any_nan & ((a_i == b_i) | both_zero);
    assign cmp_lt = ~any_nan & a_below_b & ~both_zero;

    // RISC-V FCLASS bit order, bit 0 is -inf
    assign class_mask = {
        a_cls.is_nan & ~a_cls.is_snan,         // qNaN
        a_cls.is_snan,
        ~a_cls.sign & a_cls.is_inf,
        ~a_cls.sign & a_cls.is_normal,
        ~a_cls.sign & a_cls.is_subnormal,
        ~a_cls.sign & a_cls.is_zero,
        a_cls.sign & a_cls.is_zero,
        a_cls.sign & a_cls.is_subnormal,
        a_cls.sign & a_cls.is_normal,
        a_cls.sign & a_cls.is_inf              // -inf
    };

    always_comb begin
        result_o = '0;
        fflags_o = '0;
        case (op_i)
            SGNJ:   result_o = {b_i[31], a_i[30:0]};
            SGNJN:  result_o = {~b_i[31], a_i[30:0]};
            SGNJX:  result_o = {a_i[31] ^ b_i[31], a_i[30:0]};
            FMIN, FMAX: begin
                fflags_o.nv = any_snan;
                if (a_cls.is_nan && b_cls.is_nan) begin
                    result_o = CANONICAL_NAN;
                end else if (a_cls.is_nan) begin
                    result_o = b_i;
                end else if (b_cls.is_nan) begin
                    result_o = a_i;
                end else if ((op_i == FMIN) == a_below_b) begin
                    result_o = a_i;
                end else begin
                    result_o = b_i;
                end
            end
            FEQ: begin
                result_o    = {31'b0, cmp_eq};
                fflags_o.nv = any_snan;  // Quiet compare
            end
            FLT: begin
                result_o    = {31'b0, cmp_lt};
                fflags_o.nv = any_nan;   // Signalling compare
            end
            FLE: begin
                result_o    = {31'b0, cmp_lt | cmp_eq};
                fflags_o.nv = any_nan;
            end
            FCLASS: result_o = {{(32-CLASS_MASK_W){1'b0}}, class_mask};
            default: result_o = '0;
        endcase
    end

endmodule

//--- fpu/fpu_pipeline.sv
`timescale 1ns/1ns

module fpu_pipeline #(
    parameter int DATA_W  = 32,
    parameter int LATENCY = 2
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              valid_i,
    output logic              ready_o,
    input  logic [DATA_W-1:0] data_i,
    output logic              valid_o,
    input  logic              ready_i,
    output logic [DATA_W-1:0] data_o
);

    logic [LATENCY-1:0]             vld_q;
    logic [LATENCY-1:0][DATA_W-1:0] dat_q;
    logic [LATENCY-1:0]             up_valid;
    logic [LATENCY-1:0][DATA_W-1:0] up_data;
    logic [LATENCY-1:0]             dn_ready;
    logic [LATENCY-1:0]             stg_ready;

    for (genvar i = 0; i < LATENCY; i++) begin : g_stage
        if (i == 0) begin : g_first
            assign up_valid[i] = valid_i;
            assign up_data[i]  = data_i;
        end else begin : g_mid
            assign up_valid[i] = vld_q[i-1];
            assign up_data[i]  = dat_q[i-1];
        end

        if (i == LATENCY - 1) begin : g_last
            assign dn_ready[i] = ready_i;
        end else begin : g_inner
            assign dn_ready[i] = stg_ready[i+1];
        end

        // Free slot or the next stage drains this one
        assign stg_ready[i] = ~vld_q[i] | dn_ready[i];

        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                vld_q[i] <= 1'b0;
            end else if (stg_ready[i]) begin
                vld_q[i] <= up_valid[i];
            end
        end

        always_ff @(posedge clk) begin
            if (stg_ready[i] && up_valid[i]) begin
                dat_q[i] <= up_data[i];
            end
        end
    end

    assign ready_o = stg_ready[0];
    assign valid_o = vld_q[LATENCY-1];
    assign data_o  = dat_q[LATENCY-1];

    a_out_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("fpu_pipeline: output changed while stalled");

endmodule

//--- fpu/fpu_unit.sv
`timescale 1ns/1ns

module fpu_unit #(
    parameter int NUM_LANES = 4,
    parameter int TAGW      = 4,
    parameter int LATENCY   = 2
) (
    input  logic                               clk,
    input  logic                               arst_n_i,

    input  logic                               valid_i,
    output logic                               ready_o,
    input  logic [TAGW-1:0]                    tag_i,
    input  fpu_pkg::fpu_op_e                   op_type_i,
    input  fpu_pkg::frm_t                      frm_i,
    input  fpu_pkg::fp32_t   [NUM_LANES-1:0]   dataa_i,
    input  fpu_pkg::fp32_t   [NUM_LANES-1:0]   datab_i,

    output logic                               valid_o,
    input  logic                               ready_i,
    output logic [TAGW-1:0]                    tag_o,
    output fpu_pkg::fp32_t   [NUM_LANES-1:0]   result_o,
    output logic                               has_fflags_o,
    output fpu_pkg::fflags_t [NUM_LANES-1:0]   fflags_o
);
    import fpu_pkg::*;

    typedef struct packed {
        logic [TAGW-1:0]           tag;
        logic                      has_fflags;
        fp32_t   [NUM_LANES-1:0]   result;
        fflags_t [NUM_LANES-1:0]   fflags;
    } payload_t;

    localparam int DATA_W = $bits(payload_t);

    noncomp_op_e                 dec_op;
    logic                        dec_has_fflags;
    fp32_t   [NUM_LANES-1:0]     lane_result;
    fflags_t [NUM_LANES-1:0]     lane_fflags;
    payload_t                    pipe_in;
    payload_t                    pipe_out;

    always_comb begin
        dec_op         = SGNJ;
        dec_has_fflags = 1'b0;
        case (op_type_i)
            FPU_MISC: begin
                case (frm_i)
                    FRM_SGNJ:  dec_op = SGNJ;
                    FRM_SGNJN: dec_op = SGNJN;
                    FRM_SGNJX: dec_op = SGNJX;
                    FRM_FMIN: begin
                        dec_op         = FMIN;
                        dec_has_fflags = 1'b1;
                    end
                    FRM_FMAX: begin
                        dec_op         = FMAX;
                        dec_has_fflags = 1'b1;
                    end
                    default:   dec_op = SGNJ;
                endcase
            end
            FPU_CMP: begin
                dec_has_fflags = 1'b1;
                case (frm_i)
                    FRM_FLE: dec_op = FLE;
                    FRM_FLT: dec_op = FLT;
                    FRM_FEQ: dec_op = FEQ;
                    default: dec_op = FEQ;  // Unused codes
                endcase
            end
            FPU_CLASS: dec_op = FCLASS;
            default:   dec_op = SGNJ;
        endcase
    end

    // One datapath per thread lane, all driven by the same decode
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        fpu_noncomp_lane lane_i (
            .op_i     (dec_op),
            .a_i      (dataa_i[l]),
            .b_i      (datab_i[l]),
            .result_o (lane_result[l]),
            .fflags_o (lane_fflags[l])
        );
    end

    assign pipe_in.tag        = tag_i;
    assign pipe_in.has_fflags = dec_has_fflags;
    assign pipe_in.result     = lane_result;
    assign pipe_in.fflags     = lane_fflags;

    fpu_pipeline #(
        .DATA_W  (DATA_W),
        .LATENCY (LATENCY)
    ) pipeline_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .ready_o  (ready_o),
        .data_i   (pipe_in),
        .valid_o  (valid_o),
        .ready_i  (ready_i),
        .data_o   (pipe_out)
    );

    assign tag_o        = pipe_out.tag;
    assign has_fflags_o = pipe_out.has_fflags;
    assign result_o     = pipe_out.result;
    assign fflags_o     = pipe_out.fflags;

    a_op_supported: assert property (@(posedge clk) disable iff (!arst_n_i)
        valid_i && ready_o |-> op_type_i inside {FPU_CMP, FPU_CLASS, FPU_MISC})
    else $error("fpu_unit: unsupported op_type %0d accepted", op_type_i);

    // Request must not change while waiting for ready_o
    a_in_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        valid_i && !ready_o |=>
            valid_i && $stable({tag_i, op_type_i, frm_i, dataa_i, datab_i}))
    else $error("fpu_unit: request changed while stalled");

endmodule

//--- bench/fpu_ref_model.svh
// Expected result and flags of one lane
typedef struct packed {
    fpu_pkg::fp32_t   result;
    fpu_pkg::fflags_t fflags;
} lane_ref_t;

function automatic logic is_nan_value(input logic [31:0] v);
    return (v[30:23] == 8'hff) && (v[22:0] != 23'd0);
endfunction

function automatic logic is_snan_value(input logic [31:0] v);
    return is_nan_value(v) && !v[22];  // Quiet bit clear
endfunction

// Signed ordering key, both zeros map to 0
function automatic logic signed [32:0] order_key(input logic [31:0] v);
    logic signed [32:0] mag;
    mag = {2'b00, v[30:0]};
    return v[31] ? -mag : mag;
endfunction

// One-hot class mask, bit 0 is -inf
function automatic logic [31:0] class_mask_of(input logic [31:0] v);
    int idx;
    if (v[30:23] == 8'hff) begin
        if (v[22:0] == 23'd0) begin
            idx = v[31] ? 0 : 7;
        end else begin
            idx = v[22] ? 9 : 8;
        end
    end else if (v[30:23] == 8'h00) begin
        if (v[22:0] == 23'd0) begin
            idx = v[31] ? 3 : 4;
        end else begin
            idx = v[31] ? 2 : 5;
        end
    end else begin
        idx = v[31] ? 1 : 6;
    end
    return 32'd1 << idx;
endfunction

function automatic logic ref_has_fflags(input fpu_pkg::fpu_op_e op, input logic [2:0] frm);
    if (op == fpu_pkg::FPU_CMP) begin
        return 1'b1;
    end
    return (op == fpu_pkg::FPU_MISC) && (frm == 3'd3 || frm == 3'd4);
endfunction

function automatic lane_ref_t ref_lane(input fpu_pkg::fpu_op_e op, input logic [2:0] frm,
                                       input logic [31:0] a, input logic [31:0] b);
    lane_ref_t          r;
    logic               nan_a;
    logic               nan_b;
    logic               snan_any;
    logic               a_less;
    logic signed [32:0] ka;
    logic signed [32:0] kb;
    r        = '0;
    nan_a    = is_nan_value(a);
    nan_b    = is_nan_value(b);
    snan_any = is_snan_value(a) || is_snan_value(b);
    ka       = order_key(a);
    kb       = order_key(b);
    a_less   = (ka < kb) || ((ka == kb) && a[31] && !b[31]);  // -0 below +0
    case (op)
        fpu_pkg::FPU_MISC: begin
            case (frm)
                3'd1: r.result = {~b[31], a[30:0]};
                3'd2: r.result = {a[31] ^ b[31], a[30:0]};
                3'd3, 3'd4: begin
                    r.fflags.nv = snan_any;
                    if (nan_a && nan_b) begin
                        r.result = fpu_pkg::CANONICAL_NAN;
                    end else if (nan_a) begin
                        r.result = b;
                    end else if (nan_b) begin
                        r.result = a;
                    end else if (frm == 3'd3) begin
                        r.result = a_less ? a : b;
                    end else begin
                        r.result = a_less ? b : a;
                    end
                end
                default: r.result = {b[31], a[30:0]};
            endcase
        end
        fpu_pkg::FPU_CMP: begin
            if (frm == 3'd2) begin
                r.fflags.nv = snan_any;
                r.result[0] = !nan_a && !nan_b && (ka == kb);
            end else begin
                r.fflags.nv = nan_a || nan_b;
                r.result[0] = !nan_a && !nan_b && ((frm == 3'd0) ? (ka <= kb) : (ka < kb));
            end
        end
        default: r.result = class_mask_of(a);
    endcase
    return r;
endfunction

//--- bench/fpu_unit_tb.sv
`timescale 1ns/1ns

module fpu_unit_tb;
    import fpu_pkg::*;

    `include "fpu_ref_model.svh"

    localparam int NUM_LANES   = 4;
    localparam int TAGW        = 4;
    localparam int NUM_TXN     = 2000;
    localparam int WAIT_LIMIT  = 500;
    localparam int STALL_START = 400;
    localparam int STALL_LEN   = 40;
    localparam logic [31:0] SEED = 32'hb15876ed;

    typedef struct packed {
        logic [TAGW-1:0]         tag;
        logic                    has_fflags;
        fp32_t   [NUM_LANES-1:0] result;
        fflags_t [NUM_LANES-1:0] fflags;
    } exp_item_t;

    logic                    clk = 1'b0;
    logic                    arst_n_i;
    logic                    valid_i;
    logic                    ready_o;
    logic [TAGW-1:0]         tag_i;
    fpu_op_e                 op_type_i;
    frm_t                    frm_i;
    fp32_t   [NUM_LANES-1:0] dataa_i;
    fp32_t   [NUM_LANES-1:0] datab_i;
    logic                    valid_o;
    logic                    ready_i;
    logic [TAGW-1:0]         tag_o;
    fp32_t   [NUM_LANES-1:0] result_o;
    logic                    has_fflags_o;
    fflags_t [NUM_LANES-1:0] fflags_o;

    exp_item_t   exp_q[$];
    logic [31:0] stim_state    = SEED;
    logic        stall_active  = 1'b0;
    logic        saw_ready_low = 1'b0;

    fp32_t special_vals [12] = '{32'h00000000, 32'h80000000, 32'h7f800000, 32'hff800000,
                                 32'h7f800001, 32'h7fc00000, 32'hffa00000, 32'h00000001,
                                 32'h807fffff, 32'h3f800000, 32'hbf800000, 32'hffc12345};

    fpu_unit fpu_unit_i (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] stim_rand();
        stim_state = lcg_next(stim_state);
        return stim_state;
    endfunction

    // Half special values, half raw random bits
    function automatic fp32_t pick_operand();
        logic [31:0] r;
        r = stim_rand();
        if (r[31]) begin
            return special_vals[int'(r[27:24]) % 12];
        end
        return stim_rand();
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string field, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s got %h, expected %h", $time, field, got, expected);
            stop_with_failure("DUT output does not match the reference model");
        end
    endtask

    // Random back-pressure with one long stall
    initial begin
        logic [31:0] rs;
        int          cycle;
        rs      = SEED ^ 32'h5a5a5a5a;
        cycle   = 0;
        ready_i = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            cycle++;
            rs           = lcg_next(rs);
            stall_active = (cycle >= STALL_START) && (cycle < STALL_START + STALL_LEN);
            ready_i      = stall_active ? 1'b0 : ((int'(rs[31:24]) % 10) >= 3);
        end
    end

    // Output side is stable between the edges
    always @(negedge clk) begin
        exp_item_t head;
        if (arst_n_i && valid_o && ready_i) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("DUT produced an output with no request outstanding");
            end
            head = exp_q.pop_front();
            check_value("tag", 32'(tag_o), 32'(head.tag));
            check_value("has_fflags", 32'(has_fflags_o), 32'(head.has_fflags));
            for (int l = 0; l < NUM_LANES; l++) begin
                check_value($sformatf("result lane %0d", l), result_o[l], head.result[l]);
                check_value($sformatf("fflags lane %0d", l), 32'(fflags_o[l]),
                            32'(head.fflags[l]));
            end
        end
        if (stall_active && valid_i && !ready_o) begin
            saw_ready_low = 1'b1;
        end
    end

    initial begin
        int          waited;
        int          sel;
        logic [31:0] r;
        exp_item_t   item;
        lane_ref_t   lr;
        arst_n_i  = 1'b0;
        valid_i   = 1'b0;
        tag_i     = '0;
        op_type_i = FPU_MISC;
        frm_i     = '0;
        dataa_i   = '0;
        datab_i   = '0;
        repeat (4) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        @(negedge clk);
        check_value("valid_o after reset", 32'(valid_o), 32'd0);
        check_value("ready_o after reset", 32'(ready_o), 32'd1);

        for (int n = 0; n < NUM_TXN; n++) begin
            @(posedge clk);
            #1;
            r = stim_rand();
            if (r[31:29] == 3'd0) begin  // Idle cycle
                valid_i = 1'b0;
                @(posedge clk);
                #1;
            end
            r     = stim_rand();
            sel   = int'(r[31:24]) % 10;
            tag_i = r[19:16];
            if (sel < 5) begin
                op_type_i = FPU_MISC;
                frm_i     = frm_t'(sel);
            end else if (sel < 8) begin
                op_type_i = FPU_CMP;
                frm_i     = frm_t'(sel - 5);
            end else if (sel == 8) begin
                op_type_i = FPU_CLASS;
                frm_i     = r[22:20];
            end else begin
                op_type_i = FPU_MISC;  // Unused function codes
                frm_i     = frm_t'(5 + int'(r[21:20]) % 3);
            end
            item.tag        = tag_i;
            item.has_fflags = ref_has_fflags(op_type_i, frm_i);
            for (int l = 0; l < NUM_LANES; l++) begin
                dataa_i[l]     = pick_operand();
                datab_i[l]     = pick_operand();
                lr             = ref_lane(op_type_i, frm_i, dataa_i[l], datab_i[l]);
                item.result[l] = lr.result;
                item.fflags[l] = lr.fflags;
            end
            valid_i = 1'b1;
            waited  = 0;
            @(negedge clk);
            while (!ready_o) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    stop_with_failure("input handshake stalled, ready_o stayed low");
                end
                @(negedge clk);
            end
            exp_q.push_back(item);
        end
        @(posedge clk);
        #1;
        valid_i = 1'b0;

        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_with_failure("output handshake stalled, results never drained");
            end
            @(negedge clk);
        end
        // Last result has left, nothing may follow it
        @(negedge clk);
        check_value("valid_o after drain", 32'(valid_o), 32'd0);
        if (!saw_ready_low) begin
            stop_with_failure("ready_o never dropped during the long ready_i stall");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

//--- vlog.f
+incdir+bench
common/fpu_pkg.sv
fpu/fpu_classify.sv
fpu/fpu_noncomp_lane.sv
fpu/fpu_pipeline.sv
fpu/fpu_unit.sv
bench/fpu_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module fpu_unit_tb \
    -Mdir obj_dir \
    -o fpu_unit_sim

./obj_dir/fpu_unit_sim 2>&1 | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
